// File: list.f
cdb_config_pkg.sv
fu_ops_pkg.sv
alu_unit.sv
mult_unit.sv
psel_gen.sv
cdb_arbiter.sv
writeback_top.sv
writeback_asserts.sv
tb_writeback.sv

// File: tb_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module tb_writeback
    import cdb_config_pkg::*, fu_ops_pkg::*;
();

    typedef struct packed {
        alu_op_t               op;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
    } alu_req_t;

    typedef struct packed {
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
    } mult_req_t;

    // ops issued per test, they size the timeout
    localparam int alu_test_ops    = 13;
    localparam int mult_test_ops   = 4;
    localparam int branch_test_ops = 8;
    localparam int contend_rounds  = 3;
    localparam int contend_ops     = 4 * contend_rounds;
    localparam int load_test_ops   = 20;
    localparam int total_ops       = alu_test_ops + mult_test_ops + branch_test_ops
                                   + contend_ops + load_test_ops;
    localparam int timeout_cycles  = total_ops * (mult_steps + 4) + 100;
    localparam int num_rob         = 1 << robn_width;

    logic clock = 1'b0;
    logic reset;

    logic [num_alu-1:0]                 alu_issue;
    alu_op_t [num_alu-1:0]              alu_op;
    logic [num_alu-1:0][data_width-1:0] alu_a;
    logic [num_alu-1:0][data_width-1:0] alu_b;
    logic [num_alu-1:0][robn_width-1:0] alu_robn;
    logic [num_alu-1:0][prn_width-1:0]  alu_dest_prn;
    logic [num_alu-1:0]                 alu_ready;

    logic                  mult_issue;
    logic [data_width-1:0] mult_a;
    logic [data_width-1:0] mult_b;
    logic [robn_width-1:0] mult_robn;
    logic [prn_width-1:0]  mult_dest_prn;
    logic                  mult_ready;

    logic                  load_prepared;
    logic [data_width-1:0] load_data;
    logic [prn_width-1:0]  load_dest_prn;
    logic [robn_width-1:0] load_robn;
    logic                  load_selected;

    logic [cdb_width-1:0]                 cdb_valid;
    logic [cdb_width-1:0][prn_width-1:0]  cdb_dest_prn;
    logic [cdb_width-1:0][data_width-1:0] cdb_value;
    logic [cdb_width-1:0][robn_width-1:0] cdb_robn;
    logic [num_alu-1:0]                   branch_valid;
    logic [num_alu-1:0][robn_width-1:0]   branch_robn;
    logic [num_alu-1:0]                   branch_taken;

    // scoreboard, indexed by ROB number
    logic [num_rob-1:0]    in_flight;
    logic [data_width-1:0] exp_value  [num_rob];
    logic [prn_width-1:0]  exp_prn    [num_rob];
    int                    exp_src    [num_rob];
    logic                  exp_branch [num_rob];

    alu_req_t              alu_q [num_alu][$];
    mult_req_t             mult_q [$];
    logic [data_width-1:0] load_q [$];

    // load slot occupancy as seen from the source side
    logic                  load_full;
    logic                  load_take;
    logic [robn_width-1:0] next_robn;

    int    errors;
    int    checks;
    int    tests_run;
    int    issued;
    int    both_lanes;
    int    load_waits;
    int    cycle_count;
    int    test_start;
    int    seed;
    string test_name;

    always #10 clock = ~clock;

    writeback_top writeback_top_i (.*);

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [data_width-1:0] expected,
                               input logic [data_width-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name,
                     expected, actual);
            errors++;
        end
    endtask

    function automatic logic [data_width-1:0] expected_alu(input alu_op_t op,
            input logic [data_width-1:0] a, input logic [data_width-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            op_beq:  return (a == b) ? 1 : 0;
            op_bne:  return (a != b) ? 1 : 0;
            default: return '0;
        endcase
    endfunction

    function automatic alu_op_t random_value_op();
        return alu_op_t'($urandom_range(5, 0));
    endfunction

    function automatic logic work_pending();
        logic busy;
        busy = (|in_flight) || load_prepared || (mult_q.size() > 0) || (load_q.size() > 0);
        for (int u = 0; u < num_alu; u++) begin
            busy = busy || (alu_q[u].size() > 0);
        end
        return busy;
    endfunction

    task automatic claim_robn(output logic [robn_width-1:0] r);
        int n;
        n = 0;
        while (in_flight[next_robn] && n < num_rob) begin
            next_robn++;
            n++;
        end
        expect_true(!in_flight[next_robn], "no free ROB number left to issue with");
        r = next_robn;
        in_flight[r] = 1'b1;
        next_robn++;
        issued++;
    endtask

    task automatic check_outputs();
        logic [robn_width-1:0] r;
        if (&cdb_valid) begin
            both_lanes++;
            expect_true(exp_src[cdb_robn[0]] < exp_src[cdb_robn[1]],
                        "bus lanes not filled in priority order");
        end
        for (int k = 0; k < cdb_width; k++) begin
            if (cdb_valid[k]) begin
                r = cdb_robn[k];
                expect_true(in_flight[r] && !exp_branch[r],
                            $sformatf("lane %0d carries ROB %0d, which awaits no result", k, r));
                if (in_flight[r] && !exp_branch[r]) begin
                    check_value($sformatf("cdb_value[%0d]", k), exp_value[r], cdb_value[k]);
                    check_value($sformatf("cdb_dest_prn[%0d]", k), data_width'(exp_prn[r]),
                                data_width'(cdb_dest_prn[k]));
                    in_flight[r] = 1'b0;
                end
            end
        end
        for (int i = 0; i < num_alu; i++) begin
            if (branch_valid[i]) begin
                r = branch_robn[i];
                expect_true(in_flight[r] && exp_branch[r],
                            $sformatf("branch port %0d resolves ROB %0d, no branch pending", i, r));
                if (in_flight[r] && exp_branch[r]) begin
                    check_value($sformatf("branch_taken[%0d]", i), data_width'(exp_value[r][0]),
                                data_width'(branch_taken[i]));
                    in_flight[r] = 1'b0;
                end
            end
        end
    endtask

    // one cycle: check the bus, then drive the next inputs
    task automatic drive_cycle();
        alu_req_t              areq;
        mult_req_t             mreq;
        logic [robn_width-1:0] r;
        logic [prn_width-1:0]  prn;
        @(negedge clock);
        check_outputs();
        for (int u = 0; u < num_alu; u++) begin
            alu_issue[u] = 1'b0;
            if (alu_ready[u] && alu_q[u].size() > 0) begin
                areq = alu_q[u].pop_front();
                claim_robn(r);
                prn = prn_width'($urandom);
                alu_issue[u]    = 1'b1;
                alu_op[u]       = areq.op;
                alu_a[u]        = areq.a;
                alu_b[u]        = areq.b;
                alu_robn[u]     = r;
                alu_dest_prn[u] = prn;
                exp_value[r]  = expected_alu(areq.op, areq.a, areq.b);
                exp_prn[r]    = prn;
                exp_src[r]    = u;
                exp_branch[r] = (areq.op == op_beq) || (areq.op == op_bne);
            end
        end
        mult_issue = 1'b0;
        if (mult_ready && mult_q.size() > 0) begin
            mreq = mult_q.pop_front();
            claim_robn(r);
            prn = prn_width'($urandom);
            mult_issue    = 1'b1;
            mult_a        = mreq.a;
            mult_b        = mreq.b;
            mult_robn     = r;
            mult_dest_prn = prn;
            exp_value[r]  = mreq.a * mreq.b;
            exp_prn[r]    = prn;
            exp_src[r]    = num_alu;
            exp_branch[r] = 1'b0;
        end
        // the presented load went into the slot at the last edge
        if (load_take) begin
            load_full = load_prepared;
        end
        if (load_take || !load_prepared) begin
            load_prepared = 1'b0;
            if (load_q.size() > 0) begin
                claim_robn(r);
                prn = prn_width'($urandom);
                load_prepared = 1'b1;
                load_data     = load_q.pop_front();
                load_dest_prn = prn;
                load_robn     = r;
                exp_value[r]  = load_data;
                exp_prn[r]    = prn;
                exp_src[r]    = num_alu + num_mult;
                exp_branch[r] = 1'b0;
            end
        end
        load_take = load_selected || !load_full;
        if (load_prepared && !load_take) begin
            load_waits++;
        end
    endtask

    task automatic run_until_idle();
        while (work_pending()) begin
            drive_cycle();
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        $display("test %s finished with %0d errors", test_name, errors - test_start);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout, results still outstanding after %0d cycles", timeout_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        seed = $urandom(39);
        errors = 0;
        checks = 0;
        tests_run = 0;
        issued = 0;
        both_lanes = 0;
        load_waits = 0;
        in_flight = '0;
        next_robn = '0;
        load_full = 1'b0;
        load_take = 1'b0;

        reset = 1'b1;
        alu_issue = '0;
        for (int u = 0; u < num_alu; u++) begin
            alu_op[u] = op_add;
        end
        alu_a = '0;
        alu_b = '0;
        alu_robn = '0;
        alu_dest_prn = '0;
        mult_issue = 1'b0;
        mult_a = '0;
        mult_b = '0;
        mult_robn = '0;
        mult_dest_prn = '0;
        load_prepared = 1'b0;
        load_data = '0;
        load_dest_prn = '0;
        load_robn = '0;

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        start_test("reset");
        check_value("cdb_valid", '0, data_width'(cdb_valid));
        check_value("branch_valid", '0, data_width'(branch_valid));
        check_value("load_selected", '0, data_width'(load_selected));
        check_value("alu_ready", data_width'({num_alu{1'b1}}), data_width'(alu_ready));
        check_value("mult_ready", 1, data_width'(mult_ready));
        finish_test();

        start_test("alu_ops");
        for (int u = 0; u < num_alu; u++) begin
            for (int op = 0; op < 6; op++) begin
                alu_q[u].push_back('{alu_op_t'(op), $urandom, $urandom});
            end
        end
        // signed compare with a negative operand
        alu_q[0].push_back('{op_slt, 32'hFFFF_FFF0, 32'h0000_0005});
        run_until_idle();
        finish_test();

        start_test("multiply");
        mult_q.push_back('{32'hFFFF_FFFF, 32'hFFFF_FFFF});
        mult_q.push_back('{32'h8000_0001, 32'h7FFF_FFFF});
        mult_q.push_back('{$urandom | 32'h8000_0000, $urandom});
        mult_q.push_back('{$urandom, $urandom | 32'hF000_0000});
        run_until_idle();
        finish_test();

        start_test("branches");
        for (int u = 0; u < num_alu; u++) begin
            seed = $urandom;
            alu_q[u].push_back('{op_beq, seed, seed});
            alu_q[u].push_back('{op_beq, seed, ~seed});
            alu_q[u].push_back('{op_bne, seed, seed});
            alu_q[u].push_back('{op_bne, seed, seed + 1});
        end
        run_until_idle();
        finish_test();

        start_test("contention");
        both_lanes = 0;
        repeat (contend_rounds) begin
            // line the ALUs and the load up with the multiplier's last busy step
            mult_q.push_back('{$urandom, $urandom});
            repeat (mult_steps) drive_cycle();
            for (int u = 0; u < num_alu; u++) begin
                alu_q[u].push_back('{random_value_op(), $urandom, $urandom});
            end
            drive_cycle();
            load_q.push_back($urandom);
            run_until_idle();
        end
        expect_true(both_lanes >= 2 * contend_rounds,
                    "four prepared sources never filled both lanes");
        finish_test();

        start_test("load_backpressure");
        load_waits = 0;
        for (int n = 0; n < 8; n++) begin
            for (int u = 0; u < num_alu; u++) begin
                alu_q[u].push_back('{random_value_op(), $urandom, $urandom});
            end
        end
        mult_q.push_back('{$urandom, $urandom});
        repeat (3) load_q.push_back($urandom);
        run_until_idle();
        expect_true(load_waits > 0, "no load was ever held back by the arbiter");
        finish_test();

        errors += writeback_top_i.writeback_asserts_i.failures;
        $display("tests %0d, ops issued %0d, checks %0d, assertion failures %0d, errors %0d",
                 tests_run, issued, checks, writeback_top_i.writeback_asserts_i.failures,
                 errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: writeback_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_asserts
    import cdb_config_pkg::*;
(
    input wire logic                                clock,
    input wire logic                                reset,
    input wire logic [cdb_width-1:0]                cdb_valid,
    input wire logic [cdb_width-1:0][robn_width-1:0] cdb_robn,
    input wire logic [num_alu-1:0]                  branch_valid,
    input wire logic                                load_prepared,
    input wire logic [data_width-1:0]               load_data,
    input wire logic [prn_width-1:0]                load_dest_prn,
    input wire logic [robn_width-1:0]               load_robn,
    input wire logic                                load_selected
);

    int unsigned failures = 0;
    logic        load_full;

    // load slot fills when empty or granted
    always_ff @(posedge clock) begin
        if (reset) begin
            load_full <= 1'b0;
        end else if (load_selected || !load_full) begin
            load_full <= load_prepared;
        end
    end

    lane_fill_order: assert property (@(posedge clock) disable iff (reset)
        cdb_valid[1] |-> cdb_valid[0])
    else begin
        $error("lane 1 valid while lane 0 idle");
        failures++;
    end

    lane_distinct_robn: assert property (@(posedge clock) disable iff (reset)
        (&cdb_valid) |-> (cdb_robn[0] != cdb_robn[1]))
    else begin
        $error("both lanes carry ROB %0d", cdb_robn[0]);
        failures++;
    end

    quiet_after_reset: assert property (@(posedge clock)
        reset |=> !(|cdb_valid) && !(|branch_valid))
    else begin
        $error("bus or branch output active right after reset");
        failures++;
    end

    // a load that the arbiter has not taken must not move
    load_held_stable: assert property (@(posedge clock) disable iff (reset)
        (load_prepared && load_full && !load_selected)
            |=> load_prepared && $stable(load_data) && $stable(load_dest_prn)
                && $stable(load_robn))
    else begin
        $error("load inputs changed before the arbiter took them");
        failures++;
    end

endmodule

bind writeback_top writeback_asserts writeback_asserts_i (
    .clock        (clock),
    .reset        (reset),
    .cdb_valid    (cdb_valid),
    .cdb_robn     (cdb_robn),
    .branch_valid (branch_valid),
    .load_prepared(load_prepared),
    .load_data    (load_data),
    .load_dest_prn(load_dest_prn),
    .load_robn    (load_robn),
    .load_selected(load_selected)
);

`default_nettype wire

// File: writeback_top.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_top
    import cdb_config_pkg::*, fu_ops_pkg::*;
(
    input  wire logic                                clock,
    input  wire logic                                reset,

    input  wire logic [num_alu-1:0]                  alu_issue,
    input  wire alu_op_t [num_alu-1:0]               alu_op,
    input  wire logic [num_alu-1:0][data_width-1:0]  alu_a,
    input  wire logic [num_alu-1:0][data_width-1:0]  alu_b,
    input  wire logic [num_alu-1:0][robn_width-1:0]  alu_robn,
    input  wire logic [num_alu-1:0][prn_width-1:0]   alu_dest_prn,
    output logic      [num_alu-1:0]                  alu_ready,

    input  wire logic                                mult_issue,
    input  wire logic [data_width-1:0]               mult_a,
    input  wire logic [data_width-1:0]               mult_b,
    input  wire logic [robn_width-1:0]               mult_robn,
    input  wire logic [prn_width-1:0]                mult_dest_prn,
    output logic                                     mult_ready,

    input  wire logic                                load_prepared,
    input  wire logic [data_width-1:0]               load_data,
    input  wire logic [prn_width-1:0]                load_dest_prn,
    input  wire logic [robn_width-1:0]               load_robn,
    output logic                                     load_selected,

    output logic [cdb_width-1:0]                     cdb_valid,
    output logic [cdb_width-1:0][prn_width-1:0]      cdb_dest_prn,
    output logic [cdb_width-1:0][data_width-1:0]     cdb_value,
    output logic [cdb_width-1:0][robn_width-1:0]     cdb_robn,

    output logic [num_alu-1:0]                       branch_valid,
    output logic [num_alu-1:0][robn_width-1:0]       branch_robn,
    output logic [num_alu-1:0]                       branch_taken
);

    logic [num_alu-1:0]                 alu_avail;
    logic [num_alu-1:0]                 alu_out_prepared;
    logic [num_alu-1:0][data_width-1:0] alu_out_result;
    logic [num_alu-1:0][prn_width-1:0]  alu_out_prn;
    logic [num_alu-1:0][robn_width-1:0] alu_out_robn;
    logic [num_alu-1:0]                 alu_out_branch;

    logic                               mult_avail;
    logic                               mult_out_prepared;
    logic [data_width-1:0]              mult_out_result;
    logic [prn_width-1:0]               mult_out_prn;
    logic [robn_width-1:0]              mult_out_robn;

    for (genvar i = 0; i < num_alu; i++) begin : g_alu
        alu_unit alu_unit_i (
            .clock       (clock),
            .reset       (reset),
            .issue       (alu_issue[i]),
            .op          (alu_op[i]),
            .a           (alu_a[i]),
            .b           (alu_b[i]),
            .robn        (alu_robn[i]),
            .dest_prn    (alu_dest_prn[i]),
            .avail       (alu_avail[i]),
            .ready       (alu_ready[i]),
            .prepared    (alu_out_prepared[i]),
            .result      (alu_out_result[i]),
            .dest_prn_out(alu_out_prn[i]),
            .robn_out    (alu_out_robn[i]),
            .cond_branch (alu_out_branch[i])
        );
    end

    mult_unit mult_unit_i (
        .clock       (clock),
        .reset       (reset),
        .issue       (mult_issue),
        .a           (mult_a),
        .b           (mult_b),
        .robn        (mult_robn),
        .dest_prn    (mult_dest_prn),
        .avail       (mult_avail),
        .ready       (mult_ready),
        .prepared    (mult_out_prepared),
        .result      (mult_out_result),
        .dest_prn_out(mult_out_prn),
        .robn_out    (mult_out_robn)
    );

    cdb_arbiter cdb_arbiter_i (
        .clock          (clock),
        .reset          (reset),
        .alu_prepared   (alu_out_prepared),
        .alu_result     (alu_out_result),
        .alu_dest_prn   (alu_out_prn),
        .alu_robn       (alu_out_robn),
        .alu_cond_branch(alu_out_branch),
        .mult_prepared  (mult_out_prepared),
        .mult_result    (mult_out_result),
        .mult_dest_prn  (mult_out_prn),
        .mult_robn      (mult_out_robn),
        .load_prepared  (load_prepared),
        .load_data      (load_data),
        .load_dest_prn  (load_dest_prn),
        .load_robn      (load_robn),
        .alu_avail      (alu_avail),
        .mult_avail     (mult_avail),
        .load_selected  (load_selected),
        .cdb_valid      (cdb_valid),
        .cdb_dest_prn   (cdb_dest_prn),
        .cdb_value      (cdb_value),
        .cdb_robn       (cdb_robn),
        .branch_valid   (branch_valid),
        .branch_robn    (branch_robn),
        .branch_taken   (branch_taken)
    );

endmodule

`default_nettype wire

// File: cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter
    import cdb_config_pkg::*;
(
    input  wire logic                                 clock,
    input  wire logic                                 reset,

    input  wire logic [num_alu-1:0]                   alu_prepared,
    input  wire logic [num_alu-1:0][data_width-1:0]   alu_result,
    input  wire logic [num_alu-1:0][prn_width-1:0]    alu_dest_prn,
    input  wire logic [num_alu-1:0][robn_width-1:0]   alu_robn,
    input  wire logic [num_alu-1:0]                   alu_cond_branch,

    input  wire logic [num_mult-1:0]                  mult_prepared,
    input  wire logic [num_mult-1:0][data_width-1:0]  mult_result,
    input  wire logic [num_mult-1:0][prn_width-1:0]   mult_dest_prn,
    input  wire logic [num_mult-1:0][robn_width-1:0]  mult_robn,

    input  wire logic [num_load-1:0]                  load_prepared,
    input  wire logic [num_load-1:0][data_width-1:0]  load_data,
    input  wire logic [num_load-1:0][prn_width-1:0]   load_dest_prn,
    input  wire logic [num_load-1:0][robn_width-1:0]  load_robn,

    output logic [num_alu-1:0]                        alu_avail,
    output logic [num_mult-1:0]                       mult_avail,
    output logic [num_load-1:0]                       load_selected,

    output logic [cdb_width-1:0]                      cdb_valid,
    output logic [cdb_width-1:0][prn_width-1:0]       cdb_dest_prn,
    output logic [cdb_width-1:0][data_width-1:0]      cdb_value,
    output logic [cdb_width-1:0][robn_width-1:0]      cdb_robn,

    output logic [num_alu-1:0]                        branch_valid,
    output logic [num_alu-1:0][robn_width-1:0]        branch_robn,
    output logic [num_alu-1:0]                        branch_taken
);

    // slot order is alu, mult, load from bit 0 upward
    logic [num_src-1:0]                 src_prepared;
    logic [num_src-1:0][data_width-1:0] src_value;
    logic [num_src-1:0][prn_width-1:0]  src_prn;
    logic [num_src-1:0][robn_width-1:0] src_robn;

    logic [num_src-1:0]                 slot_prepared;
    logic [num_src-1:0][data_width-1:0] slot_value;
    logic [num_src-1:0][prn_width-1:0]  slot_prn;
    logic [num_src-1:0][robn_width-1:0] slot_robn;
    logic [num_alu-1:0]                 slot_branch;

    logic [num_src-1:0]                 slot_is_branch;
    logic [num_src-1:0]                 slot_take;
    logic [num_src-1:0]                 req;
    logic [num_src-1:0]                 gnt;
    logic [cdb_width-1:0][num_src-1:0]  gnt_bus;

    assign src_prepared = {load_prepared, mult_prepared, alu_prepared};
    assign src_value    = {load_data, mult_result, alu_result};
    assign src_prn      = {load_dest_prn, mult_dest_prn, alu_dest_prn};
    assign src_robn     = {load_robn, mult_robn, alu_robn};

    // held branches resolve on the side port and never request a lane
    assign slot_is_branch = {{(num_src-num_alu){1'b0}},
                             slot_prepared[num_alu-1:0] & slot_branch};
    assign req = slot_prepared & ~slot_is_branch;

    psel_gen #(
        .width(num_src),
        .lanes(cdb_width)
    ) psel_gen_i (
        .req    (req),
        .gnt    (gnt),
        .gnt_bus(gnt_bus)
    );

    assign alu_avail  = ~slot_prepared[num_alu-1:0] | gnt[num_alu-1:0]
                      | slot_is_branch[num_alu-1:0];
    assign mult_avail = ~slot_prepared[num_alu +: num_mult] | gnt[num_alu +: num_mult];
    assign load_selected = gnt[num_alu+num_mult +: num_load];

    // load slot refills when granted or empty
    assign slot_take = {load_selected | ~slot_prepared[num_alu+num_mult +: num_load],
                        mult_avail, alu_avail};

    always_ff @(posedge clock) begin
        if (reset) begin
            slot_prepared <= '0;
        end else begin
            for (int i = 0; i < num_src; i++) begin
                if (slot_take[i]) begin
                    slot_prepared[i] <= src_prepared[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < num_src; i++) begin
            if (slot_take[i]) begin
                slot_value[i] <= src_value[i];
                slot_prn[i]   <= src_prn[i];
                slot_robn[i]  <= src_robn[i];
            end
        end
        for (int i = 0; i < num_alu; i++) begin
            if (alu_avail[i]) begin
                slot_branch[i] <= alu_cond_branch[i];
            end
        end
    end

    // one-hot lane muxes
    always_comb begin
        for (int k = 0; k < cdb_width; k++) begin
            cdb_valid[k]    = |gnt_bus[k];
            cdb_value[k]    = '0;
            cdb_dest_prn[k] = '0;
            cdb_robn[k]     = '0;
            for (int i = 0; i < num_src; i++) begin
                cdb_value[k]    = cdb_value[k]    | (slot_value[i] & {data_width{gnt_bus[k][i]}});
                cdb_dest_prn[k] = cdb_dest_prn[k] | (slot_prn[i]   & {prn_width{gnt_bus[k][i]}});
                cdb_robn[k]     = cdb_robn[k]     | (slot_robn[i]  & {robn_width{gnt_bus[k][i]}});
            end
        end
    end

    // branch resolve, taken bit sits in result bit 0
    always_comb begin
        for (int i = 0; i < num_alu; i++) begin
            branch_valid[i] = slot_is_branch[i];
            branch_robn[i]  = slot_robn[i];
            branch_taken[i] = slot_value[i][0];
        end
    end

endmodule

`default_nettype wire

// File: psel_gen.sv
`timescale 1ns/1ps
`default_nettype none

module psel_gen #(
    parameter int width = 4,
    parameter int lanes = 2
) (
    input  wire logic [width-1:0]            req,
    output logic      [width-1:0]            gnt,
    output logic      [lanes-1:0][width-1:0] gnt_bus
);

    // each lane peels off the lowest remaining request bit
    // bit 0 is the highest priority
    always_comb begin
        logic [width-1:0] remaining;

        remaining = req;
        gnt       = '0;
        for (int k = 0; k < lanes; k++) begin
            gnt_bus[k] = remaining & (~remaining + 1'b1);
            remaining  = remaining & ~gnt_bus[k];
            gnt        = gnt | gnt_bus[k];
        end
    end

endmodule

`default_nettype wire

// File: mult_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mult_unit
    import cdb_config_pkg::*, fu_ops_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  issue,
    input  wire logic [data_width-1:0] a,
    input  wire logic [data_width-1:0] b,
    input  wire logic [robn_width-1:0] robn,
    input  wire logic [prn_width-1:0]  dest_prn,
    input  wire logic                  avail,
    output logic                       ready,
    output logic                       prepared,
    output logic [data_width-1:0]      result,
    output logic [prn_width-1:0]       dest_prn_out,
    output logic [robn_width-1:0]      robn_out
);

    mult_state_t                state;
    logic [mult_step_width-1:0] step;
    logic [data_width-1:0]      mcand;
    logic [data_width-1:0]      mplier;
    logic [data_width-1:0]      acc;
    logic [data_width-1:0]      partial;

    // current slice of b times the shifted multiplicand, low bits only
    assign partial = mcand * data_width'(mplier[mult_slice_width-1:0]);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mult_idle;
            step  <= '0;
        end else begin
            case (state)
                mult_idle: begin
                    if (issue) begin
                        state <= mult_busy;
                        step  <= '0;
                    end
                end
                mult_busy: begin
                    step <= step + 1'b1;
                    if (step == mult_step_width'(mult_steps - 1)) begin
                        state <= mult_done;
                    end
                end
                mult_done: begin
                    // hold the result until the arbiter slot frees
                    if (avail) begin
                        state <= mult_idle;
                    end
                end
                default: state <= mult_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == mult_idle && issue) begin
            mcand        <= a;
            mplier       <= b;
            acc          <= '0;
            robn_out     <= robn;
            dest_prn_out <= dest_prn;
        end else if (state == mult_busy) begin
            acc    <= acc + partial;
            mcand  <= mcand << mult_slice_width;
            mplier <= mplier >> mult_slice_width;
        end
    end

    assign ready    = (state == mult_idle);
    assign prepared = (state == mult_done);
    assign result   = acc;

endmodule

`default_nettype wire

// File: alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import cdb_config_pkg::*, fu_ops_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  issue,
    input  wire alu_op_t               op,
    input  wire logic [data_width-1:0] a,
    input  wire logic [data_width-1:0] b,
    input  wire logic [robn_width-1:0] robn,
    input  wire logic [prn_width-1:0]  dest_prn,
    input  wire logic                  avail,
    output logic                       ready,
    output logic                       prepared,
    output logic [data_width-1:0]      result,
    output logic [prn_width-1:0]       dest_prn_out,
    output logic [robn_width-1:0]      robn_out,
    output logic                       cond_branch
);

    logic [data_width-1:0] alu_out;
    logic                  is_branch;

    // combinational execute
    always_comb begin
        is_branch = 1'b0;
        case (op)
            op_add: alu_out = a + b;
            op_sub: alu_out = a - b;
            op_and: alu_out = a & b;
            op_or:  alu_out = a | b;
            op_xor: alu_out = a ^ b;
            op_slt: alu_out = {{(data_width-1){1'b0}}, $signed(a) < $signed(b)};
            op_beq: begin
                alu_out   = {{(data_width-1){1'b0}}, a == b};
                is_branch = 1'b1;
            end
            op_bne: begin
                alu_out   = {{(data_width-1){1'b0}}, a != b};
                is_branch = 1'b1;
            end
            default: alu_out = '0;
        endcase
    end

    // the output register only moves while the arbiter slot can take it
    assign ready = avail;

    always_ff @(posedge clock) begin
        if (reset) begin
            prepared <= 1'b0;
        end else if (avail) begin
            prepared <= issue;
        end
    end

    always_ff @(posedge clock) begin
        if (avail) begin
            result       <= alu_out;
            dest_prn_out <= dest_prn;
            robn_out     <= robn;
            cond_branch  <= is_branch;
        end
    end

endmodule

`default_nettype wire

// File: fu_ops_pkg.sv
`default_nettype none

package fu_ops_pkg;

    // alu opcodes
    // beq and bne only produce a taken bit for branch resolve
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_slt = 4'd5,
        op_beq = 4'd6,
        op_bne = 4'd7
    } alu_op_t;

    // multiplier sequencing
    typedef enum logic [1:0] {
        mult_idle = 2'd0,
        mult_busy = 2'd1,
        mult_done = 2'd2
    } mult_state_t;

endpackage

`default_nettype wire

// File: cdb_config_pkg.sv
`default_nettype none

package cdb_config_pkg;

    // producer counts, one arbiter slot each
    localparam int num_alu  = 2;
    localparam int num_mult = 1;
    localparam int num_load = 1;
    localparam int num_src  = num_alu + num_mult + num_load;

    // bus lanes granted per cycle
    localparam int cdb_width = 2;

    // datapath and tag widths
    localparam int data_width = 32;
    localparam int prn_width  = 6;
    localparam int robn_width = 5;

    // iterative multiplier, one slice of b per busy cycle
    localparam int mult_steps       = 4;
    localparam int mult_step_width  = $clog2(mult_steps);
    localparam int mult_slice_width = data_width / mult_steps;

endpackage

`default_nettype wire
